// File: source/rw_gen_pkg.sv
// Shared widths, types, state encoding and FIFO sizing for the read/write generator.
// Modules refer to these by scoped names.

package rw_gen_pkg;

    // ------------------------------------------------
    // Widths that carry a meaning
    // ------------------------------------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [15:0] count_t;
    typedef logic [1:0]  module_id_t;

    // ------------------------------------------------
    // Request FIFO sizing
    // ------------------------------------------------
    localparam int FIFO_DEPTH  = 16;
    localparam int PROG_THRESH = 8;

    // Pointer indexes an entry, fill level must reach FIFO_DEPTH itself
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;

    // ------------------------------------------------
    // Routing and command encodings
    // ------------------------------------------------
    typedef enum logic [1:0] {
        CMD_MEM_READ   = 2'd0,
        CMD_MEM_WRITE  = 2'd1,
        CMD_ENGINE_RSP = 2'd2,
        CMD_CONTROL    = 2'd3
    } cmd_t;

    typedef enum logic {
        BUFFER_DATA  = 1'b0,
        BUFFER_SETUP = 1'b1
    } buffer_class_t;

    // Command stamped on every response going back to the engine
    localparam cmd_t CMD_ENGINE = CMD_ENGINE_RSP;

    // Destination module that receives setup-class responses
    localparam module_id_t SETUP_MODULE_ID = 2'd1;

    // ------------------------------------------------
    // Job state machine
    // ------------------------------------------------
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        START = 3'd1,
        BUSY  = 3'd2,
        PAUSE = 3'd3,
        DRAIN = 3'd4,
        DONE  = 3'd5
    } gen_state_t;

endpackage : rw_gen_pkg

// File: source/rw_setup_ctrl.sv
// Job controller for the read/write generator. Paces engine intake and
// decides when the job has drained and can report done.

`timescale 1ns/1ps

module rw_setup_ctrl (
    input  logic                ap_clk,
    input  logic                areset_generator,
    input  logic                start,
    input  rw_gen_pkg::count_t  cfg_item_count,
    input  logic                cfg_counter_mode,
    input  logic                item_taken,
    input  logic                fifo_empty,
    input  logic                prog_full,
    input  logic                outstanding_zero,
    output logic                data_ready,
    output logic                count_load,
    output logic                done
);

    rw_gen_pkg::gen_state_t state;
    rw_gen_pkg::gen_state_t next_state;

    rw_gen_pkg::count_t item_count;
    rw_gen_pkg::count_t taken_cnt;
    logic               counter_mode;

    logic taken_d1;
    logic taken_d2;
    logic items_done;
    logic pipe_busy;
    logic drain_ok;

    // ------------------------------------------------
    // Job bookkeeping
    // ------------------------------------------------
    assign items_done = (taken_cnt == item_count);

    // Shadow of the builder pipeline, an item sits there two cycles before the push
    assign pipe_busy = taken_d1 | taken_d2;

    assign drain_ok = fifo_empty & ~pipe_busy & (outstanding_zero | ~counter_mode);

    always_ff @(posedge ap_clk) begin
        if (state == rw_gen_pkg::IDLE && start) begin
            item_count   <= cfg_item_count;
            counter_mode <= cfg_counter_mode;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            taken_cnt <= '0;
            taken_d1  <= 1'b0;
            taken_d2  <= 1'b0;
        end else begin
            taken_d1 <= item_taken;
            taken_d2 <= taken_d1;
            if (state == rw_gen_pkg::IDLE && start) begin
                taken_cnt <= '0;
            end else if (item_taken) begin
                taken_cnt <= taken_cnt + 1'b1;
            end
        end
    end

    // ------------------------------------------------
    // State machine
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= rw_gen_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            rw_gen_pkg::IDLE: begin
                if (start) next_state = rw_gen_pkg::START;
            end
            rw_gen_pkg::START: begin
                next_state = rw_gen_pkg::BUSY;
            end
            rw_gen_pkg::BUSY: begin
                // Completion wins over a pause request
                if (items_done) begin
                    next_state = rw_gen_pkg::DRAIN;
                end else if (prog_full) begin
                    next_state = rw_gen_pkg::PAUSE;
                end
            end
            rw_gen_pkg::PAUSE: begin
                if (!prog_full) next_state = rw_gen_pkg::BUSY;
            end
            rw_gen_pkg::DRAIN: begin
                if (drain_ok) next_state = rw_gen_pkg::DONE;
            end
            rw_gen_pkg::DONE: begin
                next_state = rw_gen_pkg::IDLE;
            end
            default: begin
                next_state = rw_gen_pkg::IDLE;
            end
        endcase
    end

    // Outputs decoded from the registered state
    assign data_ready = (state == rw_gen_pkg::BUSY) & ~items_done;
    assign count_load = (state == rw_gen_pkg::START);
    assign done       = (state == rw_gen_pkg::DONE);

endmodule : rw_setup_ctrl

// File: source/rw_request_builder.sv
// Turns accepted engine data items into addressed memory requests.
// Two register stages sit between the take and the FIFO push.

`timescale 1ns/1ps

module rw_request_builder (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               start,
    input  rw_gen_pkg::addr_t  cfg_array_pointer,
    input  rw_gen_pkg::addr_t  cfg_stride,
    input  logic               cfg_write_mode,
    input  logic               data_valid,
    input  logic               data_ready,
    input  rw_gen_pkg::data_t  data_in,
    output logic               item_taken,
    output logic               push,
    output rw_gen_pkg::addr_t  push_addr,
    output rw_gen_pkg::data_t  push_data
);

    rw_gen_pkg::addr_t stride_q;
    logic              write_mode_q;
    rw_gen_pkg::addr_t next_addr;

    logic              s1_valid;
    rw_gen_pkg::addr_t s1_addr;
    rw_gen_pkg::data_t s1_data;

    logic              s2_valid;
    rw_gen_pkg::addr_t s2_addr;
    rw_gen_pkg::data_t s2_data;

    // Items offered while data_ready is low are simply not taken
    assign item_taken = data_valid & data_ready;

    // ------------------------------------------------
    // Job configuration and running address
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (start) begin
            stride_q     <= cfg_stride;
            write_mode_q <= cfg_write_mode;
            next_addr    <= cfg_array_pointer;
        end else if (item_taken) begin
            next_addr <= next_addr + stride_q;
        end
    end

    // ------------------------------------------------
    // Pipeline
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= item_taken;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        // Stage one captures the item with its address
        s1_addr <= next_addr;
        s1_data <= data_in;
        // Stage two forms the request, reads carry no data
        s2_addr <= s1_addr;
        s2_data <= write_mode_q ? s1_data : '0;
    end

    assign push      = s2_valid;
    assign push_addr = s2_addr;
    assign push_data = s2_data;

endmodule : rw_request_builder

// File: source/rw_request_fifo.sv
// Show-ahead request queue between the builder and memory.
// A pop is a cycle with mem_req_valid and mem_req_ready both high.

`timescale 1ns/1ps

module rw_request_fifo (
    input  logic               ap_clk,
    input  logic               areset_generator,
    input  logic               push,
    input  rw_gen_pkg::addr_t  push_addr,
    input  rw_gen_pkg::data_t  push_data,
    input  logic               mem_req_ready,
    output logic               mem_req_valid,
    output rw_gen_pkg::addr_t  mem_req_addr,
    output rw_gen_pkg::data_t  mem_req_data,
    output logic               pop,
    output logic               empty,
    output logic               prog_full
);

    rw_gen_pkg::addr_t addr_mem [rw_gen_pkg::FIFO_DEPTH];
    rw_gen_pkg::data_t data_mem [rw_gen_pkg::FIFO_DEPTH];

    rw_gen_pkg::fifo_ptr_t wr_ptr;
    rw_gen_pkg::fifo_ptr_t rd_ptr;
    rw_gen_pkg::fifo_cnt_t fill;

    logic full;
    logic wr_en;

    // ------------------------------------------------
    // Flags
    // ------------------------------------------------
    assign empty     = (fill == '0);
    assign full      = (fill == rw_gen_pkg::fifo_cnt_t'(rw_gen_pkg::FIFO_DEPTH));
    assign prog_full = (fill >= rw_gen_pkg::fifo_cnt_t'(rw_gen_pkg::PROG_THRESH));

    // A push into a full queue is dropped
    assign wr_en = push & ~full;

    assign mem_req_valid = ~empty;
    assign pop           = mem_req_valid & mem_req_ready;
    assign mem_req_addr  = addr_mem[rd_ptr];
    assign mem_req_data  = data_mem[rd_ptr];

    // ------------------------------------------------
    // Storage
    // ------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            addr_mem[wr_ptr] <= push_addr;
            data_mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (pop)   rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

endmodule : rw_request_fifo

// File: source/rw_response_router.sv
// Routes memory responses back to the engine one cycle later and tracks
// how many requests are still waiting for a response.

`timescale 1ns/1ps

module rw_response_router (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  logic                       count_load,
    input  logic                       pop,
    input  logic                       mem_rsp_valid,
    input  rw_gen_pkg::data_t          mem_rsp_data,
    input  rw_gen_pkg::module_id_t     mem_rsp_to_module,
    output logic                       eng_rsp_valid,
    output rw_gen_pkg::data_t          eng_rsp_data,
    output rw_gen_pkg::cmd_t           eng_rsp_cmd,
    output rw_gen_pkg::buffer_class_t  eng_rsp_class,
    output logic                       outstanding_zero
);

    rw_gen_pkg::count_t        outstanding;
    rw_gen_pkg::buffer_class_t rsp_class;

    // ------------------------------------------------
    // Response path
    // ------------------------------------------------
    assign rsp_class = (mem_rsp_to_module == rw_gen_pkg::SETUP_MODULE_ID) ?
                       rw_gen_pkg::BUFFER_SETUP : rw_gen_pkg::BUFFER_DATA;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            eng_rsp_valid <= 1'b0;
        end else begin
            eng_rsp_valid <= mem_rsp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        eng_rsp_data  <= mem_rsp_data;
        eng_rsp_cmd   <= rw_gen_pkg::CMD_ENGINE;
        eng_rsp_class <= rsp_class;
    end

    // ------------------------------------------------
    // Outstanding requests
    // ------------------------------------------------
    // Pop and response in one cycle cancel out
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            outstanding <= '0;
        end else if (count_load) begin
            outstanding <= '0;
        end else begin
            case ({pop, mem_rsp_valid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    assign outstanding_zero = (outstanding == '0);

endmodule : rw_response_router

// File: source/rw_generator_top.sv
// Top of the read/write generator: controller, request builder,
// request FIFO and response router.

`timescale 1ns/1ps

module rw_generator_top (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  logic                       start,
    input  rw_gen_pkg::addr_t          cfg_array_pointer,
    input  rw_gen_pkg::addr_t          cfg_stride,
    input  rw_gen_pkg::count_t         cfg_item_count,
    input  logic                       cfg_write_mode,
    input  logic                       cfg_counter_mode,
    input  logic                       data_valid,
    input  rw_gen_pkg::data_t          data_in,
    output logic                       data_ready,
    output logic                       mem_req_valid,
    input  logic                       mem_req_ready,
    output rw_gen_pkg::addr_t          mem_req_addr,
    output rw_gen_pkg::data_t          mem_req_data,
    input  logic                       mem_rsp_valid,
    input  rw_gen_pkg::data_t          mem_rsp_data,
    input  rw_gen_pkg::module_id_t     mem_rsp_to_module,
    output logic                       eng_rsp_valid,
    output rw_gen_pkg::data_t          eng_rsp_data,
    output rw_gen_pkg::cmd_t           eng_rsp_cmd,
    output rw_gen_pkg::buffer_class_t  eng_rsp_class,
    output logic                       done
);

    logic              item_taken;
    logic              push;
    rw_gen_pkg::addr_t push_addr;
    rw_gen_pkg::data_t push_data;
    logic              pop;
    logic              fifo_empty;
    logic              prog_full;
    logic              count_load;
    logic              outstanding_zero;

    // ------------------------------------------------
    // Job control
    // ------------------------------------------------
    rw_setup_ctrl rw_setup_ctrl_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .start            (start),
        .cfg_item_count   (cfg_item_count),
        .cfg_counter_mode (cfg_counter_mode),
        .item_taken       (item_taken),
        .fifo_empty       (fifo_empty),
        .prog_full        (prog_full),
        .outstanding_zero (outstanding_zero),
        .data_ready       (data_ready),
        .count_load       (count_load),
        .done             (done)
    );

    // ------------------------------------------------
    // Request path
    // ------------------------------------------------
    rw_request_builder rw_request_builder_i (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .start             (start),
        .cfg_array_pointer (cfg_array_pointer),
        .cfg_stride        (cfg_stride),
        .cfg_write_mode    (cfg_write_mode),
        .data_valid        (data_valid),
        .data_ready        (data_ready),
        .data_in           (data_in),
        .item_taken        (item_taken),
        .push              (push),
        .push_addr         (push_addr),
        .push_data         (push_data)
    );

    rw_request_fifo rw_request_fifo_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (push),
        .push_addr        (push_addr),
        .push_data        (push_data),
        .mem_req_ready    (mem_req_ready),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .mem_req_data     (mem_req_data),
        .pop              (pop),
        .empty            (fifo_empty),
        .prog_full        (prog_full)
    );

    // Response path
    rw_response_router rw_response_router_i (
        .ap_clk            (ap_clk),
        .areset_generator  (areset_generator),
        .count_load        (count_load),
        .pop               (pop),
        .mem_rsp_valid     (mem_rsp_valid),
        .mem_rsp_data      (mem_rsp_data),
        .mem_rsp_to_module (mem_rsp_to_module),
        .eng_rsp_valid     (eng_rsp_valid),
        .eng_rsp_data      (eng_rsp_data),
        .eng_rsp_cmd       (eng_rsp_cmd),
        .eng_rsp_class     (eng_rsp_class),
        .outstanding_zero  (outstanding_zero)
    );

endmodule : rw_generator_top

// File: dv/rw_generator_tb.sv
// Self-checking testbench for the read/write generator. Jobs, item data and
// expected values are read from dv/rw_generator_stim.txt before reset.

`timescale 1ns/1ps

module rw_generator_tb;

    logic                      ap_clk;
    logic                      areset_generator;
    logic                      start;
    rw_gen_pkg::addr_t         cfg_array_pointer;
    rw_gen_pkg::addr_t         cfg_stride;
    rw_gen_pkg::count_t        cfg_item_count;
    logic                      cfg_write_mode;
    logic                      cfg_counter_mode;
    logic                      data_valid;
    rw_gen_pkg::data_t         data_in;
    logic                      data_ready;
    logic                      mem_req_valid;
    logic                      mem_req_ready = 1'b0;
    rw_gen_pkg::addr_t         mem_req_addr;
    rw_gen_pkg::data_t         mem_req_data;
    logic                      mem_rsp_valid = 1'b0;
    rw_gen_pkg::data_t         mem_rsp_data = '0;
    rw_gen_pkg::module_id_t    mem_rsp_to_module = '0;
    logic                      eng_rsp_valid;
    rw_gen_pkg::data_t         eng_rsp_data;
    rw_gen_pkg::cmd_t          eng_rsp_cmd;
    rw_gen_pkg::buffer_class_t eng_rsp_class;
    logic                      done;

    // Stimulus file contents, one entry per job or per item
    rw_gen_pkg::addr_t         job_ptr_q[$];
    rw_gen_pkg::addr_t         job_stride_q[$];
    int                        job_n_q[$];
    logic                      job_wm_q[$];
    logic                      job_cm_q[$];
    int                        job_pat_q[$];
    int                        job_base_q[$];
    rw_gen_pkg::data_t         item_q[$];
    rw_gen_pkg::addr_t         exp_addr_q[$];
    rw_gen_pkg::data_t         rsp_data_q[$];
    rw_gen_pkg::module_id_t    rsp_mod_q[$];
    rw_gen_pkg::buffer_class_t exp_class_q[$];

    // Job currently running
    int   cur_base;
    int   cur_n;
    logic cur_wm;
    logic cur_cm;
    int   cur_pat;
    logic job_active;

    int cycle = 0;
    int job_start_cycle = 0;
    int first_take_cycle = 0;
    int take_count = 0;
    int req_count = 0;
    int rsp_count = 0;
    int eng_count = 0;
    int done_count = 0;
    int due_q[$];
    int seed = 19;
    int limit_cycles = 0;

    rw_generator_top rw_generator_top_i (.*);

    initial begin
        ap_clk = 1'b0;
        forever #20 ap_clk = ~ap_clk;
    end

    // --------------------------------------------------
    // Failure reporting and compare tasks
    // --------------------------------------------------
    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compare_addr(input string name, input rw_gen_pkg::addr_t got,
                                input rw_gen_pkg::addr_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_data(input string name, input rw_gen_pkg::data_t got,
                                input rw_gen_pkg::data_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_cmd(input string name, input rw_gen_pkg::cmd_t got,
                               input rw_gen_pkg::cmd_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_class(input string name, input rw_gen_pkg::buffer_class_t got,
                                 input rw_gen_pkg::buffer_class_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_count(input string name, input rw_gen_pkg::count_t got,
                                 input rw_gen_pkg::count_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // --------------------------------------------------
    // Memory model and output monitors
    // --------------------------------------------------
    always @(posedge ap_clk) begin : bus_model
        int rnd;
        int due;
        int k;
        cycle = cycle + 1;
        if (start) begin
            take_count = 0;
            req_count = 0;
            rsp_count = 0;
            eng_count = 0;
            done_count = 0;
            job_start_cycle = cycle;
        end
        if (data_valid && data_ready) begin
            if (take_count == 0) first_take_cycle = cycle;
            take_count = take_count + 1;
        end
        // Request popped on this edge, schedule its response 1 to 4 cycles on
        if (mem_req_valid && mem_req_ready) begin
            if (req_count >= cur_n) begin
                $display("More memory requests than items in the job at %0t", $time);
                abort_run();
            end else begin
                k = cur_base + req_count;
                if (cur_pat == 0 && req_count == 0) begin
                    compare_count("first request latency",
                                  rw_gen_pkg::count_t'(cycle - first_take_cycle), 16'd3);
                end
                compare_addr("mem_req_addr", mem_req_addr, exp_addr_q[k]);
                compare_data("mem_req_data", mem_req_data,
                             cur_wm ? item_q[k] : rw_gen_pkg::data_t'(0));
                req_count = req_count + 1;
                rnd = $random(seed);
                due = cycle + int'(rnd[1:0]) + 1;
                // Keep responses in request order
                if (due_q.size() > 0 && due <= due_q[$]) due = due_q[$] + 1;
                due_q.push_back(due);
            end
        end
        if (eng_rsp_valid) begin
            if (eng_count >= cur_n) begin
                $display("More engine responses than items in the job at %0t", $time);
                abort_run();
            end else begin
                k = cur_base + eng_count;
                compare_data("eng_rsp_data", eng_rsp_data, rsp_data_q[k]);
                compare_cmd("eng_rsp_cmd", eng_rsp_cmd, rw_gen_pkg::CMD_ENGINE);
                compare_class("eng_rsp_class", eng_rsp_class, exp_class_q[k]);
                eng_count = eng_count + 1;
            end
        end
        if (done) begin
            done_count = done_count + 1;
            compare_bit("mem_req_valid", mem_req_valid, 1'b0);
            compare_count("requests at done", rw_gen_pkg::count_t'(req_count),
                          rw_gen_pkg::count_t'(cur_n));
            // Every response has already passed through to the engine
            if (cur_cm) begin
                compare_count("responses at done", rw_gen_pkg::count_t'(eng_count),
                              rw_gen_pkg::count_t'(cur_n));
            end
        end
        if (due_q.size() > 0 && due_q[0] == cycle) begin
            due = due_q.pop_front();
            k = cur_base + rsp_count;
            mem_rsp_valid <= 1'b1;
            mem_rsp_data <= rsp_data_q[k];
            mem_rsp_to_module <= rsp_mod_q[k];
            rsp_count = rsp_count + 1;
        end else begin
            mem_rsp_valid <= 1'b0;
        end
        // Ready patterns: 0 always, 1 stall for 30 cycles, 2 random
        if (!job_active) begin
            mem_req_ready <= 1'b0;
        end else if (cur_pat == 1) begin
            if (cycle - job_start_cycle == 30) compare_bit("data_ready", data_ready, 1'b0);
            mem_req_ready <= (cycle - job_start_cycle >= 30);
        end else if (cur_pat == 2) begin
            rnd = $random(seed);
            mem_req_ready <= rnd[0];
        end else begin
            mem_req_ready <= 1'b1;
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge ap_clk);
        $display("Watchdog expired after %0d cycles with jobs still running", limit_cycles);
        abort_run();
    end

    // --------------------------------------------------
    // Stimulus file and job sequence
    // --------------------------------------------------
    initial begin : main_flow
        int                 fd;
        int                 n_f;
        int                 total_items;
        int                 total_cfg;
        int                 j;
        int                 i;
        int                 base;
        int                 v0;
        int                 v1;
        int                 v2;
        int                 v3;
        string              line;
        rw_gen_pkg::addr_t  a0;
        rw_gen_pkg::addr_t  a1;
        rw_gen_pkg::data_t  d0;
        rw_gen_pkg::data_t  d1;
        areset_generator <= 1'b1;
        start <= 1'b0;
        cfg_array_pointer <= '0;
        cfg_stride <= '0;
        cfg_item_count <= '0;
        cfg_write_mode <= 1'b0;
        cfg_counter_mode <= 1'b0;
        data_valid <= 1'b0;
        data_in <= '0;
        cur_base <= 0;
        cur_n <= 0;
        cur_wm <= 1'b0;
        cur_cm <= 1'b0;
        cur_pat <= 0;
        job_active <= 1'b0;
        total_items = 0;
        total_cfg = 0;
        fd = $fopen("dv/rw_generator_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file dv/rw_generator_stim.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n_f = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") continue;
            if (line.getc(0) == "J") begin
                n_f = $sscanf(line, "J %h %h %d %d %d %d", a0, a1, v0, v1, v2, v3);
                if (n_f != 6) begin
                    $display("Job line in the stimulus file is malformed: %s", line);
                    abort_run();
                end
                job_ptr_q.push_back(a0);
                job_stride_q.push_back(a1);
                job_n_q.push_back(v0);
                job_wm_q.push_back(v1[0]);
                job_cm_q.push_back(v2[0]);
                job_pat_q.push_back(v3);
                job_base_q.push_back(item_q.size());
                total_cfg = total_cfg + v0;
            end else begin
                n_f = $sscanf(line, "D %h %h %h %d %d", d0, a0, d1, v0, v1);
                if (n_f != 5 || job_n_q.size() == 0) begin
                    $display("Item line in the stimulus file is malformed: %s", line);
                    abort_run();
                end
                item_q.push_back(d0);
                exp_addr_q.push_back(a0);
                rsp_data_q.push_back(d1);
                rsp_mod_q.push_back(rw_gen_pkg::module_id_t'(v0));
                exp_class_q.push_back(rw_gen_pkg::buffer_class_t'(v1));
                total_items = total_items + 1;
            end
        end
        $fclose(fd);
        if (total_items != total_cfg || total_items == 0) begin
            $display("Item lines in the stimulus file do not match the job counts");
            abort_run();
        end
        limit_cycles = 200 * total_items + 1000;

        repeat (5) @(posedge ap_clk);
        areset_generator <= 1'b0;
        @(posedge ap_clk);
        compare_bit("data_ready", data_ready, 1'b0);
        compare_bit("mem_req_valid", mem_req_valid, 1'b0);
        compare_bit("eng_rsp_valid", eng_rsp_valid, 1'b0);
        compare_bit("done", done, 1'b0);

        for (j = 0; j < job_n_q.size(); j++) begin
            base = job_base_q[j];
            start <= 1'b1;
            cfg_array_pointer <= job_ptr_q[j];
            cfg_stride <= job_stride_q[j];
            cfg_item_count <= rw_gen_pkg::count_t'(job_n_q[j]);
            cfg_write_mode <= job_wm_q[j];
            cfg_counter_mode <= job_cm_q[j];
            cur_base <= base;
            cur_n <= job_n_q[j];
            cur_wm <= job_wm_q[j];
            cur_cm <= job_cm_q[j];
            cur_pat <= job_pat_q[j];
            job_active <= 1'b1;
            @(posedge ap_clk);
            start <= 1'b0;
            // Offered early, must be ignored until data_ready rises
            data_valid <= 1'b1;
            data_in <= item_q[base];
            @(posedge ap_clk);
            compare_bit("data_ready", data_ready, 1'b0);
            @(posedge ap_clk);
            compare_bit("data_ready", data_ready, 1'b1);
            for (i = 1; i < job_n_q[j]; i++) begin
                data_in <= item_q[base + i];
                @(posedge ap_clk);
                while (!data_ready) @(posedge ap_clk);
            end
            data_valid <= 1'b0;
            while (done_count == 0) @(posedge ap_clk);
            while (eng_count < job_n_q[j]) @(posedge ap_clk);
            repeat (5) @(posedge ap_clk);
            compare_count("done pulses", rw_gen_pkg::count_t'(done_count), 16'd1);
            compare_count("items taken", rw_gen_pkg::count_t'(take_count),
                          rw_gen_pkg::count_t'(job_n_q[j]));
            compare_count("engine responses", rw_gen_pkg::count_t'(eng_count),
                          rw_gen_pkg::count_t'(job_n_q[j]));
            job_active <= 1'b0;
            @(posedge ap_clk);
        end
        $display("Regression passed");
        $finish;
    end

endmodule : rw_generator_tb

// File: dv/rw_generator_stim.txt
# J pointer stride item_count write_mode counter_mode ready_pattern (0 ready, 1 stall, 2 random)
# D item_data expected_addr rsp_data rsp_to_module expected_class (1 setup, 0 data)
# Write job, memory always ready
J 00001000 00000004 4 1 1 0
D a5a50001 00001000 c0de0001 0 0
D a5a50002 00001004 c0de0002 1 1
D a5a50003 00001008 c0de0003 2 0
D a5a50004 0000100c c0de0004 3 0
# Read job, random ready
J 80000000 00000040 5 0 1 2
D 11110000 80000000 0badf00d 1 1
D 22220000 80000040 0badf00e 0 0
D 33330000 80000080 0badf00f 1 1
D 44440000 800000c0 0badf010 2 0
D 55550000 80000100 0badf011 3 0
# Write job with a long stall to hit the FIFO threshold
J 00002000 00000008 16 1 1 1
D 00000100 00002000 beef0000 0 0
D 00000101 00002008 beef0001 1 1
D 00000102 00002010 beef0002 2 0
D 00000103 00002018 beef0003 3 0
D 00000104 00002020 beef0004 0 0
D 00000105 00002028 beef0005 1 1
D 00000106 00002030 beef0006 2 0
D 00000107 00002038 beef0007 3 0
D 00000108 00002040 beef0008 0 0
D 00000109 00002048 beef0009 1 1
D 0000010a 00002050 beef000a 2 0
D 0000010b 00002058 beef000b 3 0
D 0000010c 00002060 beef000c 0 0
D 0000010d 00002068 beef000d 1 1
D 0000010e 00002070 beef000e 2 0
D 0000010f 00002078 beef000f 3 0
# Write job without counter mode, address wraps
J fffffff0 00000010 3 1 0 2
D 5a5a0001 fffffff0 77770001 1 1
D 5a5a0002 00000000 77770002 3 0
D 5a5a0003 00000010 77770003 0 0

// File: rw_generator_top.f
source/rw_gen_pkg.sv
source/rw_setup_ctrl.sv
source/rw_request_builder.sv
source/rw_request_fifo.sv
source/rw_response_router.sv
source/rw_generator_top.sv
dv/rw_generator_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the generator testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f rw_generator_top.f --top-module rw_generator_tb \
    -o rw_generator_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build did not complete"
    exit 1
fi

./obj_dir/rw_generator_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Regression passed$" "$SIM_LOG"; then
    exit 0
fi
echo "Pass line missing from $SIM_LOG"
exit 1
